// File: project.f
+incdir+test
verilog/ecc_code_pkg.sv
verilog/ecc_status_pkg.sv
verilog/ecc_parity_gen.sv
verilog/ecc_syndrome_decode.sv
verilog/ecc_correct_stage.sv
verilog/ecc_119_cal.sv
test/ecc_tb.sv

// File: test/ecc_model.svh
`ifndef ECC_MODEL_SVH
`define ECC_MODEL_SVH

////////////////////////////////////////////////////////////
// reference model of the SEC-DED code
////////////////////////////////////////////////////////////

parity_t model_col [DATA_WIDTH];   // check column of each data bit

function automatic int unsigned ones_count(input int unsigned v);
    int unsigned n;
    n = 0;
    for (int k = 0; k < 32; k++) begin
        n += (v >> k) & 1;
    end
    return n;
endfunction

// walk upward from 3, skipping powers of two
function automatic void build_columns();
    int unsigned v;
    int unsigned idx;
    parity_t     col;
    v   = 3;
    idx = 0;
    while (idx < DATA_WIDTH) begin
        if (ones_count(v) != 1) begin
            col[6:0]       = v[6:0];
            col[7]         = ((ones_count(v) % 2) == 0);   // odd column weight
            model_col[idx] = col;
            idx++;
        end
        v++;
    end
endfunction

function automatic parity_t model_encode(input data_t d);
    parity_t p;
    p = '0;
    for (int i = 0; i < DATA_WIDTH; i++) begin
        if (d[i]) begin
            p ^= model_col[i];
        end
    end
    return p;
endfunction

function automatic void model_decode(input data_t d, input parity_t p, input logic byp,
                                     output data_t exp_data, output data_t exp_mask,
                                     output err_code_t exp_flags);
    parity_t s;
    s        = model_encode(d) ^ p;
    exp_mask = '0;
    for (int i = 0; i < DATA_WIDTH; i++) begin
        if (s == model_col[i]) begin
            exp_mask[i] = 1'b1;
        end
    end
    if (s == '0) begin
        exp_flags = ERR_NONE;
    end else if (exp_mask != '0) begin
        exp_flags = ERR_SINGLE;
    end else if (ones_count(s) == 1) begin
        exp_flags = ERR_SINGLE;   // a check bit flipped
    end else begin
        exp_flags = ERR_DOUBLE;
    end
    exp_data = d ^ exp_mask;
    if (byp) begin
        exp_data  = d;   // mask still reported
        exp_flags = ERR_NONE;
    end
endfunction

`endif

// File: test/ecc_tb.sv
module ecc_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import ecc_code_pkg::*;
    import ecc_status_pkg::*;

    localparam int SEED        = 2617;
    localparam int PHASE_WORDS = 40;
    localparam int MAX_GAP     = 3;
    localparam int DRAIN_LIMIT = 20;
    localparam int ALL_BITS    = DATA_WIDTH + PARITY_WIDTH;

    localparam int KIND_CLEAN  = 0;
    localparam int KIND_DATA   = 1;
    localparam int KIND_CHECK  = 2;
    localparam int KIND_DOUBLE = 3;
    localparam int KIND_ANY    = 4;

    logic    clk;
    logic    rst_n;
    logic    in_valid;
    logic    bypass;
    data_t   data_in;
    parity_t parity_in;
    parity_t parity_out;
    logic    out_valid;
    data_t   data_out;
    data_t   mask;
    logic    sbit_err;
    logic    dbit_err;

    data_t     exp_data_q[$];   // one entry per sampled word
    data_t     exp_mask_q[$];
    err_code_t exp_flag_q[$];
    logic      valid_due;       // in_valid as seen by the next rising edge

    `include "ecc_model.svh"

    ecc_119_cal DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .bypass     (bypass),
        .data_in    (data_in),
        .parity_in  (parity_in),
        .parity_out (parity_out),
        .out_valid  (out_valid),
        .data_out   (data_out),
        .mask       (mask),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    ////////////////////////////////////////////////////////////
    // error reporting and compare tasks
    ////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string msg);
        $display("Mismatch at time %0t: %s", $time, msg);
        $display("Verification failed");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic report_failure(input string msg);
        $display("Error at time %0t: %s", $time, msg);
        $display("Verification failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(input data_t got, input data_t exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s data_out %h, expected %h", what, got, exp));
        end
    endtask

    task automatic check_parity(input parity_t got, input parity_t exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s parity_out %h, expected %h", what, got, exp));
        end
    endtask

    task automatic check_mask(input data_t got, input data_t exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s mask %h, expected %h", what, got, exp));
        end
    endtask

    task automatic check_flags(input err_code_t got, input err_code_t exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s {dbit,sbit} %b, expected %b", what, got, exp));
        end
    endtask

    task automatic check_valid(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s out_valid %b, expected %b", what, got, exp));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    function automatic data_t random_data();
        return data_t'({$urandom(), $urandom(), $urandom(), $urandom()});
    endfunction

    // positions past the data word are check bits
    task automatic flip_bit(inout data_t d, inout parity_t p, input int unsigned pos);
        if (pos < DATA_WIDTH) begin
            d[pos] = ~d[pos];
        end else begin
            p[pos - DATA_WIDTH] = ~p[pos - DATA_WIDTH];
        end
    endtask

    task automatic make_word(input int kind, output data_t d, output parity_t p);
        int unsigned a;
        int unsigned b;
        d = random_data();
        p = model_encode(d);
        case (kind)
            KIND_DATA: begin
                flip_bit(d, p, $urandom % DATA_WIDTH);
            end
            KIND_CHECK: begin
                flip_bit(d, p, DATA_WIDTH + ($urandom % PARITY_WIDTH));
            end
            KIND_DOUBLE: begin
                a = $urandom % ALL_BITS;
                b = (a + 1 + ($urandom % (ALL_BITS - 1))) % ALL_BITS;   // never equal to a
                flip_bit(d, p, a);
                flip_bit(d, p, b);
            end
            default: begin
            end
        endcase
    endtask

    task automatic send_word(input data_t d, input parity_t p, input logic byp);
        data_t     exp_d;
        data_t     exp_m;
        err_code_t exp_f;
        @(posedge clk);
        #2;
        in_valid  = 1'b1;
        bypass    = byp;
        data_in   = d;
        parity_in = p;
        model_decode(d, p, byp, exp_d, exp_m, exp_f);
        exp_data_q.push_back(exp_d);
        exp_mask_q.push_back(exp_m);
        exp_flag_q.push_back(exp_f);
    endtask

    // inputs keep moving while idle so the encoder is still exercised
    task automatic idle_cycle();
        @(posedge clk);
        #2;
        in_valid  = 1'b0;
        bypass    = $urandom % 2;
        data_in   = random_data();
        parity_in = $urandom;
    endtask

    task automatic run_phase(input int kind, input int count, input logic byp,
                             input int max_gap);
        int      k;
        int      gaps;
        data_t   d;
        parity_t p;
        for (int n = 0; n < count; n++) begin
            k = (kind == KIND_ANY) ? ($urandom % 4) : kind;
            make_word(k, d, p);
            send_word(d, p, byp);
            gaps = (max_gap > 0) ? ($urandom % (max_gap + 1)) : 0;
            repeat (gaps) idle_cycle();
        end
    endtask

    task automatic drain_results();
        int cycles;
        cycles = 0;
        while ((exp_data_q.size() != 0) && (cycles < DRAIN_LIMIT)) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_data_q.size() != 0) begin
            report_failure("timed out waiting for out_valid on pending words");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // checking, mid-cycle where outputs are stable
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        data_t     exp_d;
        data_t     exp_m;
        err_code_t exp_f;
        if (rst_n) begin
            check_parity(parity_out, model_encode(data_in), "encoder");
            check_valid(out_valid, valid_due, "strobe");   // one cycle after sampling
            if (out_valid) begin
                if (exp_data_q.size() == 0) begin
                    report_failure("out_valid high with no word pending");
                end else begin
                    exp_d = exp_data_q.pop_front();
                    exp_m = exp_mask_q.pop_front();
                    exp_f = exp_flag_q.pop_front();
                    check_data(data_out, exp_d, "result");
                    check_mask(mask, exp_m, "result");
                    check_flags({dbit_err, sbit_err}, exp_f, "result");
                end
            end else begin
                check_flags({dbit_err, sbit_err}, ERR_NONE, "idle");
            end
        end
        valid_due = in_valid;
    end

    initial begin
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        bypass       = 1'b0;
        data_in      = '0;
        parity_in    = '0;
        void'($urandom(SEED));
        build_columns();

        repeat (10) @(posedge clk);
        @(negedge clk);
        check_valid(out_valid, 1'b0, "reset");
        check_flags({dbit_err, sbit_err}, ERR_NONE, "reset");
        check_data(data_out, '0, "reset");
        check_mask(mask, '0, "reset");
        @(posedge clk);
        #2;
        rst_n = 1'b1;

        run_phase(KIND_CLEAN, PHASE_WORDS, 1'b0, MAX_GAP);
        run_phase(KIND_DATA, PHASE_WORDS, 1'b0, MAX_GAP);
        run_phase(KIND_CHECK, PHASE_WORDS, 1'b0, MAX_GAP);
        run_phase(KIND_DOUBLE, PHASE_WORDS, 1'b0, MAX_GAP);
        run_phase(KIND_ANY, PHASE_WORDS, 1'b1, MAX_GAP);      // bypass
        run_phase(KIND_ANY, 2 * PHASE_WORDS, 1'b0, 0);        // back to back
        run_phase(KIND_ANY, PHASE_WORDS, 1'b0, MAX_GAP);
        idle_cycle();
        drain_results();

        $display("Verification passed");
        $finish;
    end

endmodule

// File: verilog/ecc_119_cal.sv
module ecc_119_cal (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  logic                    bypass,
    input  ecc_code_pkg::data_t     data_in,
    input  ecc_code_pkg::parity_t   parity_in,
    output ecc_code_pkg::parity_t   parity_out,
    output logic                    out_valid,
    output ecc_code_pkg::data_t     data_out,
    output ecc_code_pkg::data_t     mask,
    output logic                    sbit_err,
    output logic                    dbit_err
);

    import ecc_code_pkg::*;
    import ecc_status_pkg::*;

    syndrome_t syndrome;
    data_t     dec_mask;
    err_code_t err_code;

    ////////////////////////////////////////////////////////////
    // encode and decode, same cycle
    ////////////////////////////////////////////////////////////

    ecc_parity_gen u_parity_gen (
        .data_in    (data_in),
        .parity_out (parity_out)
    );

    assign syndrome = parity_out ^ parity_in;   // zero for a clean word

    ecc_syndrome_decode u_syndrome_decode (
        .syndrome (syndrome),
        .mask     (dec_mask),
        .err_code (err_code)
    );

    ////////////////////////////////////////////////////////////
    // correction and output register
    ////////////////////////////////////////////////////////////

    ecc_correct_stage u_correct_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .bypass    (bypass),
        .data_in   (data_in),
        .mask_in   (dec_mask),
        .err_code  (err_code),
        .out_valid (out_valid),
        .data_out  (data_out),
        .mask      (mask),
        .sbit_err  (sbit_err),
        .dbit_err  (dbit_err)
    );

endmodule

// File: verilog/ecc_code_pkg.sv
package ecc_code_pkg;

    ////////////////////////////////////////////////////////////
    // code geometry
    ////////////////////////////////////////////////////////////

    localparam int DATA_WIDTH   = 119;
    localparam int PARITY_WIDTH = 8;
    localparam int HAM_WIDTH    = 7;   // position part of the syndrome

    typedef logic [DATA_WIDTH-1:0]   data_t;       // data word, also the correction mask
    typedef logic [PARITY_WIDTH-1:0] parity_t;
    typedef logic [PARITY_WIDTH-1:0] syndrome_t;
    typedef logic [HAM_WIDTH-1:0]    position_t;

    ////////////////////////////////////////////////////////////
    // check column of a data bit
    ////////////////////////////////////////////////////////////

    // Data bit idx sits at the (idx+1)-th position from 3 upward that is
    // not a power of two. Positions 1, 2, 4, ... belong to the check bits.
    // The top bit is chosen so that every column has odd weight, which is
    // what separates a single error from a double one.
    function automatic parity_t check_column(input int unsigned idx);
        position_t   pos;
        parity_t     col;
        int unsigned n;
        pos = '0;
        n   = 0;
        for (int unsigned v = 3; v < 2 ** HAM_WIDTH; v++) begin
            if ((v & (v - 1)) != 0) begin   // skip powers of two
                if (n == idx) begin
                    pos = HAM_WIDTH'(v);
                end
                n++;
            end
        end
        col                  = '0;
        col[HAM_WIDTH-1:0]   = pos;
        col[PARITY_WIDTH-1]  = ~^pos;   // set on even weight
        return col;
    endfunction

    // true when a syndrome has exactly one bit set
    function automatic logic is_check_bit(input syndrome_t s);
        logic nonzero;
        logic single;
        nonzero = (s != '0);
        single  = ((s & (s - 1'b1)) == '0);
        return nonzero && single;
    endfunction

endpackage

// File: verilog/ecc_correct_stage.sv
module ecc_correct_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid,
    input  logic                      bypass,
    input  ecc_code_pkg::data_t       data_in,
    input  ecc_code_pkg::data_t       mask_in,
    input  ecc_status_pkg::err_code_t err_code,
    output logic                      out_valid,
    output ecc_code_pkg::data_t       data_out,
    output ecc_code_pkg::data_t       mask,
    output logic                      sbit_err,
    output logic                      dbit_err
);

    import ecc_code_pkg::*;
    import ecc_status_pkg::*;

    data_t fixed_data;
    logic  flag_en;

    assign fixed_data = bypass ? data_in : (data_in ^ mask_in);
    assign flag_en    = in_valid & ~bypass;   // bypass silences the flags

    ////////////////////////////////////////////////////////////
    // result register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            sbit_err  <= 1'b0;
            dbit_err  <= 1'b0;
            data_out  <= '0;
            mask      <= '0;
        end else begin
            out_valid <= in_valid;
            sbit_err  <= flag_en & err_code[ERR_BIT_SINGLE];   // flags last one cycle
            dbit_err  <= flag_en & err_code[ERR_BIT_DOUBLE];
            if (in_valid) begin
                data_out <= fixed_data;
                mask     <= mask_in;   // kept even under bypass
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    flags_exclusive_a: assert property (
        @(posedge clk) disable iff (!rst_n) !(sbit_err && dbit_err)
    ) else $error("single and double error flags high together");

    flags_need_valid_a: assert property (
        @(posedge clk) disable iff (!rst_n) !out_valid |-> !(sbit_err || dbit_err)
    ) else $error("error flag high without out_valid");

endmodule

// File: verilog/ecc_parity_gen.sv
module ecc_parity_gen (
    input  ecc_code_pkg::data_t   data_in,
    output ecc_code_pkg::parity_t parity_out
);

    import ecc_code_pkg::*;

    ////////////////////////////////////////////////////////////
    // check bits
    ////////////////////////////////////////////////////////////

    // every data bit feeds each check bit its column marks
    always_comb begin
        parity_t acc;
        acc = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            acc = acc ^ ({PARITY_WIDTH{data_in[i]}} & check_column(i));
        end
        parity_out = acc;
    end

endmodule

// File: verilog/ecc_status_pkg.sv
package ecc_status_pkg;

    ////////////////////////////////////////////////////////////
    // error class, same bit meaning as the old error vector
    ////////////////////////////////////////////////////////////

    typedef logic [1:0] err_code_t;

    localparam int ERR_BIT_SINGLE = 0;
    localparam int ERR_BIT_DOUBLE = 1;

    localparam err_code_t ERR_NONE   = 2'b00;
    localparam err_code_t ERR_SINGLE = 2'b01;   // data or check bit, correctable
    localparam err_code_t ERR_DOUBLE = 2'b10;   // detected only

endpackage

// File: verilog/ecc_syndrome_decode.sv
module ecc_syndrome_decode (
    input  ecc_code_pkg::syndrome_t   syndrome,
    output ecc_code_pkg::data_t       mask,
    output ecc_status_pkg::err_code_t err_code
);

    import ecc_code_pkg::*;
    import ecc_status_pkg::*;

    logic col_hit;     // syndrome names a data bit
    logic check_hit;   // syndrome names a check bit

    ////////////////////////////////////////////////////////////
    // correction mask
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < DATA_WIDTH; i++) begin
            mask[i] = (syndrome == check_column(i));
        end
    end

    assign col_hit   = |mask;
    assign check_hit = is_check_bit(syndrome);

    ////////////////////////////////////////////////////////////
    // error class
    ////////////////////////////////////////////////////////////

    always_comb begin
        if (syndrome == '0) begin
            err_code = ERR_NONE;
        end else if (col_hit || check_hit) begin
            err_code = ERR_SINGLE;   // check-bit errors leave the mask at zero
        end else begin
            err_code = ERR_DOUBLE;
        end
    end

    // columns are distinct, so no syndrome may select two data bits
    mask_onehot_a: assert final ($onehot0(mask))
        else $error("decode mask has more than one bit set");

endmodule
